// File: verilog.f
+incdir+include
logic/attn_pkg.sv
logic/v_row_loader.sv
logic/v_buffer.sv
logic/weighted_sum_unit.sv
logic/attn_value_stage.sv
verification/tb_attn_value_stage.sv

// File: include/tb_util.svh
// Include inside the testbench module after attn_pkg is compiled; LFSR state is shared
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Galois LFSR state seeded for repeatable stimulus
logic [15:0] lfsr_state = 16'd43179;

// Failure and check counts for the closing report
int err_count = 0;
int check_count = 0;

// One LFSR step per bit taken
// Taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
    end
    return r;
endfunction

task automatic compare_vector(input string name, input attn_pkg::acc_vector_t got,
                              input attn_pkg::acc_vector_t exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

// File: verification/tb_attn_value_stage.sv
// Directed tests of the value stage; needs attn_pkg compiled first and include/ on the search path
`timescale 1ns/1ps
`default_nettype none

module tb_attn_value_stage;
    import attn_pkg::*;

    // Longest any single wait may take, in cycles
    localparam int TIMEOUT = 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        v_clear;
    logic        elem_valid;
    elem_t       elem_data;
    logic        elem_ready;
    logic        w_valid;
    weight_t     w_data;
    logic        w_ready;
    logic        out_valid;
    acc_vector_t out_data;
    logic        out_ready;
    logic        v_loaded;

    // V rows as they should sit in the buffer
    elem_t v_rows [SEQ_LEN][D_MODEL];

    // Weights of the query in flight
    weight_t weights [SEQ_LEN];

    // Extra row stuck in the loader while the buffer is full
    elem_t spare_row [D_MODEL];

    `include "tb_util.svh"

    attn_value_stage uut (
        .clk        (clk),
        .rst        (rst),
        .v_clear    (v_clear),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .elem_ready (elem_ready),
        .w_valid    (w_valid),
        .w_data     (w_data),
        .w_ready    (w_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .v_loaded   (v_loaded)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic note_timeout(input string what);
        err_count++;
        $display("Timeout: %s did not happen within %0d cycles at %0t", what, TIMEOUT, $time);
    endtask

    // Reference: each lane is the sum of weight times element over all rows
    function automatic acc_vector_t expected_sum();
        acc_vector_t v;
        int s;
        for (int i = 0; i < D_MODEL; i++) begin
            s = 0;
            for (int r = 0; r < SEQ_LEN; r++) begin
                s += int'(weights[r]) * int'(v_rows[r][i]);
            end
            v[i] = acc_t'(s);
        end
        return v;
    endfunction

    function automatic void fill_random_rows(input int first);
        for (int r = first; r < SEQ_LEN; r++) begin
            for (int i = 0; i < D_MODEL; i++) begin
                v_rows[r][i] = elem_t'(rand_bits(ELEM_W));
            end
        end
    endfunction

    function automatic void random_weights();
        for (int r = 0; r < SEQ_LEN; r++) begin
            weights[r] = weight_t'(rand_bits(WEIGHT_W));
        end
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_element(input elem_t e);
        int n;
        n = 0;
        elem_valid = 1'b1;
        elem_data  = e;
        while (!elem_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!elem_ready) begin
            note_timeout("element accept");
        end
        @(negedge clk);
        elem_valid = 1'b0;
    endtask

    // Lane 0 goes first
    task automatic send_row(input int r);
        for (int i = 0; i < D_MODEL; i++) begin
            send_element(v_rows[r][i]);
        end
    endtask

    task automatic send_weight(input weight_t w);
        int n;
        n = 0;
        w_valid = 1'b1;
        w_data  = w;
        while (!w_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!w_ready) begin
            note_timeout("weight accept");
        end
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    // Result is due one cycle after the last weight
    task automatic send_query();
        for (int r = 0; r < SEQ_LEN; r++) begin
            send_weight(weights[r]);
        end
        compare_bit("out_valid after last weight", out_valid, 1'b1);
    endtask

    task automatic take_result(input acc_vector_t exp, input string name);
        int n;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            note_timeout("result valid");
        end
        compare_vector(name, out_data, exp);
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic test_reset();
        compare_bit("elem_ready", elem_ready, 1'b1);
        compare_bit("v_loaded", v_loaded, 1'b0);
        compare_bit("w_ready", w_ready, 1'b0);
        compare_bit("out_valid", out_valid, 1'b0);
        // Weights offered before any V must be refused
        w_valid = 1'b1;
        w_data  = weight_t'(1);
        repeat (5) begin
            @(negedge clk);
            compare_bit("w_ready before load", w_ready, 1'b0);
        end
        w_valid = 1'b0;
    endtask

    task automatic test_loading();
        fill_random_rows(0);
        for (int r = 0; r < SEQ_LEN; r++) begin
            send_row(r);
        end
        // Last row still waits in the loader
        compare_bit("v_loaded before last write", v_loaded, 1'b0);
        @(negedge clk);
        // Last row went in on the edge just passed
        compare_bit("elem_ready after last write", elem_ready, 1'b1);
        compare_bit("v_loaded after last write", v_loaded, 1'b1);
        for (int i = 0; i < D_MODEL; i++) begin
            spare_row[i] = elem_t'(rand_bits(ELEM_W));
            send_element(spare_row[i]);
        end
        // Full buffer keeps the extra row and stalls the stream
        repeat (10) begin
            compare_bit("elem_ready while full", elem_ready, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic test_row_select(input int k);
        acc_vector_t exp;
        for (int r = 0; r < SEQ_LEN; r++) begin
            weights[r] = (r == k) ? weight_t'(1) : weight_t'(0);
        end
        // Row k sign extended to the lane width
        for (int i = 0; i < D_MODEL; i++) begin
            exp[i] = acc_t'(v_rows[k][i]);
        end
        send_query();
        take_result(exp, $sformatf("out_data row %0d", k));
    endtask

    task automatic test_replay();
        repeat (3) begin
            random_weights();
            send_query();
            take_result(expected_sum(), "out_data replay");
        end
    endtask

    task automatic test_backpressure();
        acc_vector_t held;
        random_weights();
        send_query();
        held = out_data;
        repeat (20) begin
            @(negedge clk);
            compare_bit("w_ready during stall", w_ready, 1'b0);
            compare_bit("out_valid during stall", out_valid, 1'b1);
            compare_vector("out_data during stall", out_data, held);
        end
        take_result(expected_sum(), "out_data after stall");
        random_weights();
        send_query();
        take_result(expected_sum(), "out_data after stall next query");
    endtask

    task automatic test_clear_reload();
        int n;
        v_clear = 1'b1;
        @(negedge clk);
        v_clear = 1'b0;
        compare_bit("v_loaded after clear", v_loaded, 1'b0);
        // Row held in the loader lands first in the new sequence
        for (int i = 0; i < D_MODEL; i++) begin
            v_rows[0][i] = spare_row[i];
        end
        fill_random_rows(1);
        for (int r = 1; r < SEQ_LEN; r++) begin
            send_row(r);
        end
        n = 0;
        while (!v_loaded && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!v_loaded) begin
            note_timeout("reload of V");
        end
        random_weights();
        send_query();
        take_result(expected_sum(), "out_data after reload");
    endtask

    initial begin
        rst        = 1'b1;
        v_clear    = 1'b0;
        elem_valid = 1'b0;
        elem_data  = '0;
        w_valid    = 1'b0;
        w_data     = '0;
        out_ready  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_loading();
        test_row_select(0);
        test_row_select(SEQ_LEN - 1);
        test_replay();
        test_backpressure();
        test_clear_reload();

        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/attn_value_stage.sv
// Load SEQ_LEN rows before sending weights; v_clear only between queries
`timescale 1ns/1ps
`default_nettype none

module attn_value_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  v_clear,
    input  logic                  elem_valid,
    input  attn_pkg::elem_t       elem_data,
    output logic                  elem_ready,
    input  logic                  w_valid,
    input  attn_pkg::weight_t     w_data,
    output logic                  w_ready,
    output logic                  out_valid,
    output attn_pkg::acc_vector_t out_data,
    input  logic                  out_ready,
    output logic                  v_loaded
);
    import attn_pkg::*;

    // Loader to buffer
    logic      row_valid;
    v_vector_t row_data;
    logic      sram_ready;

    // Buffer to weighted-sum unit
    v_vector_t v_row;
    logic      v_consume;

    // Element stream into rows
    v_row_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .elem_ready (elem_ready),
        .row_valid  (row_valid),
        .row_data   (row_data),
        .sram_ready (sram_ready)
    );

    // Value store, its valid flag doubles as v_loaded
    v_buffer u_buffer (
        .clk             (clk),
        .rst             (rst),
        .v_clear         (v_clear),
        .write_enable    (row_valid),
        .write_data      (row_data),
        .sram_ready      (sram_ready),
        .read_enable     (v_consume),
        .read_data       (v_row),
        .read_data_valid (v_loaded)
    );

    // Weights times rows
    weighted_sum_unit u_wsum (
        .clk       (clk),
        .rst       (rst),
        .w_valid   (w_valid),
        .w_data    (w_data),
        .w_ready   (w_ready),
        .v_valid   (v_loaded),
        .v_row     (v_row),
        .v_consume (v_consume),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: logic/weighted_sum_unit.sv
// Weights are unsigned; sums are not saturated and at most one result is pending
`timescale 1ns/1ps
`default_nettype none

module weighted_sum_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  w_valid,
    input  attn_pkg::weight_t     w_data,
    output logic                  w_ready,
    input  logic                  v_valid,
    input  attn_pkg::v_vector_t   v_row,
    output logic                  v_consume,
    output logic                  out_valid,
    output attn_pkg::acc_vector_t out_data,
    input  logic                  out_ready
);
    import attn_pkg::*;

    // Position of the next weight within the query
    row_idx_t w_cnt;

    // Running sums per lane
    acc_vector_t acc_q;

    // Finished vector waiting for the consumer
    acc_vector_t res_q;

    // Next sums including the current product
    acc_vector_t sum_next;
    acc_vector_t prod;

    // Weight with a zero sign bit so the multiply stays signed
    logic signed [WEIGHT_W:0] w_signed;

    logic first_w;
    logic last_w;

    assign w_signed = {1'b0, w_data};
    assign first_w  = (w_cnt == '0);
    assign last_w   = (w_cnt == ROW_IDX_W'(SEQ_LEN - 1));

    // Hold weights back while a result waits
    assign w_ready = v_valid && !out_valid;

    // Each accepted weight uses up one row
    assign v_consume = w_valid && w_ready;

    assign out_data = res_q;

    // Per-lane multiply-accumulate
    always_comb begin
        for (int i = 0; i < D_MODEL; i++) begin
            prod[i] = acc_t'(w_signed) * acc_t'(v_row[i]);
            // First weight of a query restarts the lane
            sum_next[i] = first_w ? prod[i] : acc_q[i] + prod[i];
        end
    end

    // Accumulators and result register
    always_ff @(posedge clk) begin
        if (v_consume) begin
            acc_q <= sum_next;
            if (last_w) begin
                res_q <= sum_next;
            end
        end
    end

    // Weight counter and result flag
    always_ff @(posedge clk) begin
        if (rst) begin
            w_cnt     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (v_consume) begin
                // Wraps to 0 after the last weight
                w_cnt <= w_cnt + 1'b1;
                if (last_w) begin
                    out_valid <= 1'b1;
                end
            end
            // Result taken
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/v_buffer.sv
// Written once per sequence, then replayed; reads need a full buffer and clear only at read pointer 0
`timescale 1ns/1ps
`default_nettype none

module v_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                v_clear,
    input  logic                write_enable,
    input  attn_pkg::v_vector_t write_data,
    output logic                sram_ready,
    input  logic                read_enable,
    output attn_pkg::v_vector_t read_data,
    output logic                read_data_valid
);
    import attn_pkg::*;

    // Row storage
    v_vector_t mem [SEQ_LEN];

    // Write count stops at SEQ_LEN, one extra bit to mark full
    logic [ROW_IDX_W:0] wr_cnt;

    // Read pointer wraps so each query sees rows 0 to SEQ_LEN-1
    row_idx_t rd_ptr;

    logic full;
    logic wr_fire;

    assign full    = (wr_cnt == (ROW_IDX_W + 1)'(SEQ_LEN));
    assign wr_fire = write_enable && sram_ready;

    // Accept rows until full
    assign sram_ready = !full;

    // Whole sequence must be present before any read
    assign read_data_valid = full;

    // Combinational read at the pointer
    assign read_data = mem[rd_ptr];

    // Row store
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_cnt[ROW_IDX_W-1:0]] <= write_data;
        end
    end

    // Pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
            rd_ptr <= '0;
        end else if (v_clear) begin
            // New sequence, a write on this edge is dropped
            wr_cnt <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            // Consumer only reads valid rows, checked below
            if (read_enable) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Weighted-sum unit may only consume a valid row
    read_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        read_enable |-> read_data_valid
    );

    // Write count never runs past the end of the store
    write_stops_at_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_fire |=> (wr_cnt <= (ROW_IDX_W + 1)'(SEQ_LEN))
    );

    // Clear only between queries
    clear_between_queries: assert property (
        @(posedge clk) disable iff (rst)
        v_clear |-> (rd_ptr == '0)
    );

endmodule

`default_nettype wire

// File: logic/v_row_loader.sv
// Elements arrive lane 0 first; a finished row stalls the element stream until the buffer takes it
`timescale 1ns/1ps
`default_nettype none

module v_row_loader (
    input  logic                clk,
    input  logic                rst,
    input  logic                elem_valid,
    input  attn_pkg::elem_t     elem_data,
    output logic                elem_ready,
    output logic                row_valid,
    output attn_pkg::v_vector_t row_data,
    input  logic                sram_ready
);
    import attn_pkg::*;

    // Next lane to fill
    logic [LANE_W-1:0] lane;

    // Row under construction, then held as the pending write
    v_vector_t row_q;

    logic elem_fire;
    logic last_lane;

    // Only take elements while no row waits for the buffer
    assign elem_ready = !row_valid;
    assign elem_fire  = elem_valid && elem_ready;
    assign last_lane  = (lane == LANE_W'(D_MODEL - 1));

    assign row_data = row_q;

    // Lane steering into the row register
    always_ff @(posedge clk) begin
        if (elem_fire) begin
            row_q[lane] <= elem_data;
        end
    end

    // Lane counter and pending-row flag
    always_ff @(posedge clk) begin
        if (rst) begin
            lane      <= '0;
            row_valid <= 1'b0;
        end else begin
            if (elem_fire) begin
                if (last_lane) begin
                    lane      <= '0;
                    // Row is complete on the same edge as its last element
                    row_valid <= 1'b1;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
            // Buffer took the row
            if (row_valid && sram_ready) begin
                row_valid <= 1'b0;
            end
        end
    end

    // Held row must not change while the buffer pushes back
    row_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (row_valid && !sram_ready) |=> (row_valid && $stable(row_data))
    );

endmodule

`default_nettype wire

// File: logic/attn_pkg.sv
// Sizes are fixed here; SEQ_LEN and D_MODEL must stay powers of two for pointer wrap
`default_nettype none

package attn_pkg;

    // Elements per V row and per output vector
    localparam int D_MODEL = 4;

    // Rows per sequence, also weights per query
    localparam int SEQ_LEN = 8;

    // Signed V element width
    localparam int ELEM_W = 8;

    // Unsigned attention weight width
    localparam int WEIGHT_W = 8;

    // Accumulator lane width, sized for SEQ_LEN full-scale products
    localparam int ACC_W = 20;

    // Index widths derived from the sizes above
    localparam int ROW_IDX_W = $clog2(SEQ_LEN);
    localparam int LANE_W = $clog2(D_MODEL);

    // One V element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // One attention weight, always non-negative
    typedef logic [WEIGHT_W-1:0] weight_t;

    // One accumulator lane
    typedef logic signed [ACC_W-1:0] acc_t;

    // Full V row, lane 0 in the low bits
    typedef elem_t [D_MODEL-1:0] v_vector_t;

    // Full output vector, lane 0 in the low bits
    typedef acc_t [D_MODEL-1:0] acc_vector_t;

    // Row index into the value buffer
    typedef logic [ROW_IDX_W-1:0] row_idx_t;

endpackage

`default_nettype wire
